//--- source/lsu_pkg.sv
// shared widths and encodings for the load/store unit
// imported by every RTL block and by the testbench and assertion files
package lsu_pkg;

  ////////////////////////////////////////
  // widths
  ////////////////////////////////////////

  // data path of registers and of the memory bus
  localparam int unsigned DataWidth   = 32;
  // byte address coming from the core
  localparam int unsigned AddrWidth   = 32;
  // one enable per byte lane
  localparam int unsigned BeWidth     = DataWidth / 8;
  // byte offset within a bus word
  localparam int unsigned OffsetWidth = 2;

  ////////////////////////////////////////
  // encodings
  ////////////////////////////////////////

  // access size, 2'b11 decodes as byte as well
  typedef enum logic [1:0] {
    LSU_WORD = 2'b00,
    LSU_HALF = 2'b01,
    LSU_BYTE = 2'b10
  } lsu_type_e;

  // bus handshake states of the controller
  typedef enum logic [2:0] {
    IDLE,
    WAIT_GNT_MIS,
    WAIT_RVALID_MIS,
    WAIT_GNT,
    WAIT_RVALID_MIS_GNTS_DONE
  } lsu_fsm_e;

endpackage

//--- source/lsu_ctrl_fsm.sv
// bus handshake controller of the load/store unit
// accepts one core access, splits misaligned ones into two word requests,
// tracks the outstanding response and merges the error flags of both parts
module lsu_ctrl_fsm import lsu_pkg::*; (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  // core request
  input  logic                 req_valid_i,
  input  lsu_type_e            req_type_i,
  input  logic [AddrWidth-1:0] req_addr_i,
  output logic                 req_ready_o,
  // bus address phase
  output logic                 data_req_o,
  output logic [AddrWidth-1:0] data_addr_o,
  input  logic                 data_gnt_i,
  // bus response phase
  input  logic                 data_rvalid_i,
  input  logic                 data_err_i,
  // to the alignment blocks
  output logic                 mis_second_o,
  output logic                 ctrl_update_o,
  output logic                 first_rvalid_o,
  // core response
  output logic                 resp_valid_o,
  output logic                 resp_err_o
);

  lsu_fsm_e               fsm_q, fsm_d;
  logic                   mis_q, mis_d;
  logic                   err_q, err_d;
  logic                   pend_q, pend_d;
  logic                   split_access;
  logic                   last_gnt;
  logic [OffsetWidth-1:0] offset;
  logic [AddrWidth-1:0]   word_addr;

  assign offset = req_addr_i[OffsetWidth-1:0];

  // word with an offset, or half word crossing into the next word
  assign split_access = ((req_type_i == LSU_WORD) && (offset != '0)) ||
                        ((req_type_i == LSU_HALF) && (offset == 2'b11));

  ////////////////////////////////////////
  // next state
  ////////////////////////////////////////

  always_comb begin
    fsm_d          = fsm_q;
    mis_d          = mis_q;
    err_d          = err_q;
    data_req_o     = 1'b0;
    last_gnt       = 1'b0;
    first_rvalid_o = 1'b0;

    unique case (fsm_q)
      IDLE: begin
        // new request only once the old response is in or arriving now
        if (req_valid_i && (!pend_q || data_rvalid_i)) begin
          data_req_o = 1'b1;
          // old error is done with, whether or not the grant comes now
          err_d      = 1'b0;
          if (data_gnt_i) begin
            mis_d    = split_access;
            last_gnt = !split_access;
            fsm_d    = split_access ? WAIT_RVALID_MIS : IDLE;
          end else begin
            fsm_d    = split_access ? WAIT_GNT_MIS : WAIT_GNT;
          end
        end
      end

      WAIT_GNT_MIS: begin
        data_req_o = 1'b1;
        if (data_gnt_i) begin
          mis_d = 1'b1;
          fsm_d = WAIT_RVALID_MIS;
        end
      end

      WAIT_RVALID_MIS: begin
        // second part goes out right away
        data_req_o = 1'b1;
        last_gnt   = data_gnt_i;
        if (data_rvalid_i) begin
          first_rvalid_o = 1'b1;
          err_d          = data_err_i;
          mis_d          = !data_gnt_i;
          fsm_d          = data_gnt_i ? IDLE : WAIT_GNT;
        end else if (data_gnt_i) begin
          mis_d = 1'b0;
          fsm_d = WAIT_RVALID_MIS_GNTS_DONE;
        end
      end

      WAIT_GNT: begin
        // aligned access or second part of a split one
        data_req_o = 1'b1;
        if (data_gnt_i) begin
          last_gnt = 1'b1;
          mis_d    = 1'b0;
          fsm_d    = IDLE;
        end
      end

      WAIT_RVALID_MIS_GNTS_DONE: begin
        // both granted, first response still due
        if (data_rvalid_i) begin
          first_rvalid_o = 1'b1;
          err_d          = data_err_i;
          fsm_d          = IDLE;
        end
      end

      default: fsm_d = IDLE;
    endcase
  end

  // a final grant opens a response, its rvalid in IDLE closes it
  assign pend_d = last_gnt | (pend_q & !resp_valid_o);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      fsm_q  <= IDLE;
      mis_q  <= 1'b0;
      err_q  <= 1'b0;
      pend_q <= 1'b0;
    end else begin
      fsm_q  <= fsm_d;
      mis_q  <= mis_d;
      err_q  <= err_d;
      pend_q <= pend_d;
    end
  end

  ////////////////////////////////////////
  // outputs
  ////////////////////////////////////////

  assign word_addr     = {req_addr_i[AddrWidth-1:OffsetWidth], {OffsetWidth{1'b0}}};
  // second part targets the following word
  assign data_addr_o   = mis_q ? word_addr + AddrWidth'(BeWidth) : word_addr;

  assign req_ready_o   = last_gnt;
  assign ctrl_update_o = data_req_o & data_gnt_i;
  assign mis_second_o  = mis_q;

  assign resp_valid_o  = (fsm_q == IDLE) & data_rvalid_i & pend_q;
  // first part error is held in err_q, second part arrives now
  assign resp_err_o    = resp_valid_o & (err_q | data_err_i);

endmodule

//--- source/lsu_wdata_align.sv
// byte enables and store data placement for one bus request
// combinational, selects first or second part of a split access
module lsu_wdata_align import lsu_pkg::*; (
  input  lsu_type_e              req_type_i,
  input  logic [OffsetWidth-1:0] req_offset_i,
  input  logic [DataWidth-1:0]   req_wdata_i,
  input  logic                   mis_second_i,
  output logic [BeWidth-1:0]     data_be_o,
  output logic [DataWidth-1:0]   data_wdata_o
);

  ////////////////////////////////////////
  // byte enables
  ////////////////////////////////////////

  always_comb begin
    unique case (req_type_i)
      LSU_WORD: begin
        // first part from the offset up, second part below it
        if (!mis_second_i) begin
          data_be_o = 4'b1111 << req_offset_i;
        end else begin
          data_be_o = ~(4'b1111 << req_offset_i);
        end
      end
      LSU_HALF: begin
        if (!mis_second_i) begin
          // offset 3 keeps only lane 3 in the first word
          data_be_o = 4'b0011 << req_offset_i;
        end else begin
          data_be_o = 4'b0001;
        end
      end
      // byte, also for the unused encoding
      default: data_be_o = 4'b0001 << req_offset_i;
    endcase
  end

  ////////////////////////////////////////
  // data rotation
  ////////////////////////////////////////

  // rotate left by whole bytes, wrapped bytes serve the second part
  always_comb begin
    unique case (req_offset_i)
      2'b01:   data_wdata_o = {req_wdata_i[23:0], req_wdata_i[31:24]};
      2'b10:   data_wdata_o = {req_wdata_i[15:0], req_wdata_i[31:16]};
      2'b11:   data_wdata_o = {req_wdata_i[7:0], req_wdata_i[31:8]};
      default: data_wdata_o = req_wdata_i;
    endcase
  end

endmodule

//--- source/lsu_rdata_align.sv
// load data path of the load/store unit
// keeps the access control from each grant and the upper bytes of a first
// part, then realigns and extends the final bus word into the response
module lsu_rdata_align import lsu_pkg::*; (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   ctrl_update_i,
  input  logic                   first_rvalid_i,
  input  logic                   req_we_i,
  input  lsu_type_e              req_type_i,
  input  logic                   req_sign_ext_i,
  input  logic [OffsetWidth-1:0] req_offset_i,
  input  logic [DataWidth-1:0]   data_rdata_i,
  output logic [DataWidth-1:0]   resp_rdata_o
);

  logic [OffsetWidth-1:0] offset_q;
  lsu_type_e              type_q;
  logic                   sign_ext_q;
  logic                   we_q;
  logic [DataWidth-1:8]   rdata_q;
  logic [DataWidth-1:0]   rdata_shift;
  logic [DataWidth-1:0]   rdata_w;
  logic [15:0]            rdata_h;
  logic [7:0]             rdata_b;

  ////////////////////////////////////////
  // captured state
  ////////////////////////////////////////

  // control of the access in flight, refreshed on every grant
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      offset_q   <= '0;
      type_q     <= LSU_WORD;
      sign_ext_q <= 1'b0;
      we_q       <= 1'b0;
    end else if (ctrl_update_i) begin
      offset_q   <= req_offset_i;
      type_q     <= req_type_i;
      sign_ext_q <= req_sign_ext_i;
      we_q       <= req_we_i;
    end
  end

  // lane 0 of a first part never belongs to a split load
  always_ff @(posedge clk_i) begin
    if (first_rvalid_i && !we_q) begin
      rdata_q <= data_rdata_i[DataWidth-1:8];
    end
  end

  ////////////////////////////////////////
  // realignment
  ////////////////////////////////////////

  // addressed byte moved down to lane 0
  assign rdata_shift = data_rdata_i >> {offset_q, 3'b000};
  assign rdata_b     = rdata_shift[7:0];
  // only offset 3 splits a half word
  assign rdata_h     = (offset_q == 2'b11) ? {data_rdata_i[7:0], rdata_q[31:24]}
                                           : rdata_shift[15:0];

  always_comb begin
    unique case (offset_q)
      2'b01:   rdata_w = {data_rdata_i[7:0], rdata_q[31:8]};
      2'b10:   rdata_w = {data_rdata_i[15:0], rdata_q[31:16]};
      2'b11:   rdata_w = {data_rdata_i[23:0], rdata_q[31:24]};
      default: rdata_w = data_rdata_i;
    endcase
  end

  // zero or sign extension by the captured size
  always_comb begin
    unique case (type_q)
      LSU_WORD: resp_rdata_o = rdata_w;
      LSU_HALF: resp_rdata_o = {{(DataWidth-16){sign_ext_q & rdata_h[15]}}, rdata_h};
      default:  resp_rdata_o = {{(DataWidth-8){sign_ext_q & rdata_b[7]}}, rdata_b};
    endcase
  end

endmodule

//--- source/lsu_top.sv
// load/store unit top level
// connects the core valid/ready port to the request/grant/response memory bus
module lsu_top import lsu_pkg::*; (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  // core request
  input  logic                 req_valid_i,
  output logic                 req_ready_o,
  input  logic                 req_we_i,
  input  lsu_type_e            req_type_i,
  input  logic                 req_sign_ext_i,
  input  logic [AddrWidth-1:0] req_addr_i,
  input  logic [DataWidth-1:0] req_wdata_i,
  // core response
  output logic                 resp_valid_o,
  output logic [DataWidth-1:0] resp_rdata_o,
  output logic                 resp_err_o,
  // memory bus
  output logic                 data_req_o,
  output logic [AddrWidth-1:0] data_addr_o,
  output logic                 data_we_o,
  output logic [BeWidth-1:0]   data_be_o,
  output logic [DataWidth-1:0] data_wdata_o,
  input  logic                 data_gnt_i,
  input  logic                 data_rvalid_i,
  input  logic [DataWidth-1:0] data_rdata_i,
  input  logic                 data_err_i
);

  logic                   mis_second;
  logic                   ctrl_update;
  logic                   first_rvalid;
  logic [OffsetWidth-1:0] req_offset;

  assign req_offset = req_addr_i[OffsetWidth-1:0];
  // core holds its fields until the last part is granted
  assign data_we_o  = req_we_i;

  lsu_ctrl_fsm u_ctrl_fsm (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .req_valid_i    (req_valid_i),
    .req_type_i     (req_type_i),
    .req_addr_i     (req_addr_i),
    .req_ready_o    (req_ready_o),
    .data_req_o     (data_req_o),
    .data_addr_o    (data_addr_o),
    .data_gnt_i     (data_gnt_i),
    .data_rvalid_i  (data_rvalid_i),
    .data_err_i     (data_err_i),
    .mis_second_o   (mis_second),
    .ctrl_update_o  (ctrl_update),
    .first_rvalid_o (first_rvalid),
    .resp_valid_o   (resp_valid_o),
    .resp_err_o     (resp_err_o)
  );

  lsu_wdata_align u_wdata_align (
    .req_type_i   (req_type_i),
    .req_offset_i (req_offset),
    .req_wdata_i  (req_wdata_i),
    .mis_second_i (mis_second),
    .data_be_o    (data_be_o),
    .data_wdata_o (data_wdata_o)
  );

  lsu_rdata_align u_rdata_align (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .ctrl_update_i  (ctrl_update),
    .first_rvalid_i (first_rvalid),
    .req_we_i       (req_we_i),
    .req_type_i     (req_type_i),
    .req_sign_ext_i (req_sign_ext_i),
    .req_offset_i   (req_offset),
    .data_rdata_i   (data_rdata_i),
    .resp_rdata_o   (resp_rdata_o)
  );

endmodule

//--- tb/lsu_sva.sv
// bus protocol and controller state checks for the load/store unit
// bound into every lsu_ctrl_fsm instance
module lsu_sva import lsu_pkg::*; (
  input logic                 clk_i,
  input logic                 rst_ni,
  input logic                 data_req_i,
  input logic [AddrWidth-1:0] data_addr_i,
  input logic                 data_gnt_i,
  input logic                 data_rvalid_i,
  input lsu_fsm_e             fsm_i
);

  timeunit 1ns;
  timeprecision 1ps;

  // granted but not yet answered bus requests
  logic [2:0] outstanding_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      outstanding_q <= '0;
    end else begin
      outstanding_q <= outstanding_q + 3'(data_req_i & data_gnt_i) - 3'(data_rvalid_i);
    end
  end

  ////////////////////////////////////////
  // properties
  ////////////////////////////////////////

  a_word_aligned: assert property (@(posedge clk_i) disable iff (!rst_ni)
    data_req_i |-> (data_addr_i[OffsetWidth-1:0] == '0))
    else $error("bus address not word aligned");

  // request and address held until the grant
  a_addr_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (data_req_i && !data_gnt_i) |=> (data_req_i && $stable(data_addr_i)))
    else $error("address phase changed before grant");

  a_outstanding: assert property (@(posedge clk_i) disable iff (!rst_ni)
    outstanding_q <= 3'd2)
    else $error("more than two bus requests outstanding");

  a_legal_state: assert property (@(posedge clk_i) disable iff (!rst_ni)
    fsm_i inside {IDLE, WAIT_GNT_MIS, WAIT_RVALID_MIS, WAIT_GNT, WAIT_RVALID_MIS_GNTS_DONE})
    else $error("controller in an illegal state");

endmodule

bind lsu_ctrl_fsm lsu_sva u_sva (
  .clk_i         (clk_i),
  .rst_ni        (rst_ni),
  .data_req_i    (data_req_o),
  .data_addr_i   (data_addr_o),
  .data_gnt_i    (data_gnt_i),
  .data_rvalid_i (data_rvalid_i),
  .fsm_i         (fsm_q)
);

//--- tb/lsu_tb.sv
// testbench for the load/store unit, random accesses against a memory bus model
// with random grant and response delays and an error window of word addresses
module lsu_tb import lsu_pkg::*; ();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int MemWords  = 64;
  localparam int ErrFirst  = 40;
  localparam int ErrLast   = 43;
  localparam int NumAccess = 600;
  localparam int Timeout   = 200;

  integer seed = 32'hbe3d_0c7b;

  logic                 clk_i;
  logic                 rst_ni;
  logic                 req_valid_i;
  logic                 req_ready_o;
  logic                 req_we_i;
  lsu_type_e            req_type_i;
  logic                 req_sign_ext_i;
  logic [AddrWidth-1:0] req_addr_i;
  logic [DataWidth-1:0] req_wdata_i;
  logic                 resp_valid_o;
  logic [DataWidth-1:0] resp_rdata_o;
  logic                 resp_err_o;
  logic                 data_req_o;
  logic [AddrWidth-1:0] data_addr_o;
  logic                 data_we_o;
  logic [BeWidth-1:0]   data_be_o;
  logic [DataWidth-1:0] data_wdata_o;
  logic                 data_gnt_i    = 1'b0;
  logic                 data_rvalid_i = 1'b0;
  logic [DataWidth-1:0] data_rdata_i  = '0;
  logic                 data_err_i    = 1'b0;

  // memory contents and the byte view the core expects
  logic [31:0] mem [MemWords];
  logic [7:0]  shadow [256];

  // expected results in acceptance order
  logic        exp_err [$];
  logic [31:0] exp_rdata [$];
  logic        exp_load [$];
  logic [31:0] exp_addr [$];
  logic        exp_split [$];
  logic [31:0] gnt_addr_q [$];
  int          resp_count = 0;

  // bus model response pipeline
  int          rsp_due [$];
  logic [31:0] rsp_data [$];
  logic        rsp_err [$];
  int          cyc = 0;
  int          last_due = 0;
  int          gnt_cnt = 0;

  lsu_top DUT (.*);

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  ////////////////////////////////////////
  // helpers
  ////////////////////////////////////////

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Test failed");
    $fatal(1, "simulation stopped on error");
  endtask

  task automatic check_equal(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      abort_run($sformatf("MISMATCH %s: got 0x%08h expected 0x%08h", name, got, exp));
    end
  endtask

  function automatic logic err_word(input logic [5:0] w);
    return (w >= 6'(ErrFirst)) && (w <= 6'(ErrLast));
  endfunction

  function automatic int access_size(input lsu_type_e t);
    case (t)
      LSU_WORD: return 4;
      LSU_HALF: return 2;
      default:  return 1;
    endcase
  endfunction

  // expected {err, data} of an access, built from the byte view
  function automatic logic [32:0] ref_access(input logic [7:0] addr, input lsu_type_e typ,
                                             input logic sext);
    logic [7:0]  b [4];
    logic [7:0]  a;
    logic [31:0] val;
    logic        err;
    err = 1'b0;
    for (int i = 0; i < 4; i++) begin
      a    = addr + 8'(i);
      b[i] = shadow[a];
      // bytes past the access size never count for the error
      if (i < access_size(typ) && err_word(a[7:2])) err = 1'b1;
    end
    case (typ)
      LSU_WORD: val = {b[3], b[2], b[1], b[0]};
      LSU_HALF: val = {{16{sext & b[1][7]}}, b[1], b[0]};
      default:  val = {{24{sext & b[0][7]}}, b[0]};
    endcase
    return {err, val};
  endfunction

  // bytes in error words are dropped by the memory as well
  task automatic store_shadow(input logic [7:0] addr, input lsu_type_e typ,
                              input logic [31:0] wdata);
    logic [7:0] a;
    for (int i = 0; i < access_size(typ); i++) begin
      a = addr + 8'(i);
      if (!err_word(a[7:2])) shadow[a] = wdata[8*i +: 8];
    end
  endtask

  ////////////////////////////////////////
  // memory bus model
  ////////////////////////////////////////

  always @(posedge clk_i) begin
    logic [5:0]  widx;
    logic [31:0] rnd;
    int          due;
    if (rst_ni) begin
      cyc = cyc + 1;
      if (data_req_o && data_gnt_i) begin
        // grant in the cycle just ended, answer 1 to 3 cycles later in order
        widx = data_addr_o[7:2];
        rnd  = $random(seed);
        due  = cyc + int'(rnd[1:0] % 3);
        if (due <= last_due) due = last_due + 1;
        last_due = due;
        if (data_we_o) begin
          for (int l = 0; l < BeWidth; l++) begin
            if (data_be_o[l] && !err_word(widx)) mem[widx][8*l +: 8] = data_wdata_o[8*l +: 8];
          end
        end
        rsp_due.push_back(due);
        rsp_data.push_back(mem[widx]);
        rsp_err.push_back(err_word(widx));
        gnt_addr_q.push_back(data_addr_o);
        // wait cycles before the next grant, zero keeps it ready
        gnt_cnt = int'(rnd[3:2]);
        data_gnt_i <= (gnt_cnt == 0);
      end else if (data_req_o) begin
        if (gnt_cnt != 0) gnt_cnt = gnt_cnt - 1;
        data_gnt_i <= (gnt_cnt == 0);
      end
      if (rsp_due.size() > 0 && rsp_due[0] == cyc) begin
        void'(rsp_due.pop_front());
        data_rvalid_i <= 1'b1;
        data_rdata_i  <= rsp_data.pop_front();
        data_err_i    <= rsp_err.pop_front();
      end else begin
        data_rvalid_i <= 1'b0;
        data_rdata_i  <= 32'hdead_beef;
        data_err_i    <= 1'b0;
      end
    end
  end

  ////////////////////////////////////////
  // response comparison
  ////////////////////////////////////////

  always @(posedge clk_i) begin
    logic [31:0] first_word;
    logic        split;
    if (rst_ni && resp_valid_o) begin
      if (exp_err.size() == 0) begin
        abort_run("a response arrived with no access outstanding");
      end else begin
        first_word = exp_addr.pop_front();
        split      = exp_split.pop_front();
        if (gnt_addr_q.size() < (split ? 2 : 1)) abort_run("a bus request of the access is missing");
        check_equal("data_addr_o", gnt_addr_q.pop_front(), first_word);
        if (split) check_equal("data_addr_o", gnt_addr_q.pop_front(), first_word + 32'd4);
        check_equal("resp_err_o", 32'(resp_err_o), 32'(exp_err[0]));
        if (exp_load[0] && !exp_err[0]) check_equal("resp_rdata_o", resp_rdata_o, exp_rdata[0]);
        void'(exp_err.pop_front());
        void'(exp_load.pop_front());
        void'(exp_rdata.pop_front());
        resp_count++;
      end
    end
  end

  ////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////

  initial begin
    logic [31:0] rnd;
    logic [31:0] acc_wdata;
    logic [7:0]  acc_addr;
    lsu_type_e   acc_typ;
    logic        acc_we;
    logic        acc_sext;
    logic [32:0] expv;
    logic        accepted;
    int          waited;
    rst_ni         = 1'b0;
    req_valid_i    = 1'b0;
    req_we_i       = 1'b0;
    req_type_i     = LSU_WORD;
    req_sign_ext_i = 1'b0;
    req_addr_i     = '0;
    req_wdata_i    = '0;
    // every byte differs with its address, both sign values occur
    for (int a = 0; a < 256; a++) begin
      shadow[a] = 8'(a * 37 + 145);
      mem[a / 4][8*(a % 4) +: 8] = shadow[a];
    end
    repeat (4) @(posedge clk_i);
    rst_ni <= 1'b1;
    for (int n = 0; n < NumAccess; n++) begin
      rnd       = $random(seed);
      acc_wdata = $random(seed);
      acc_addr  = rnd[15:8];
      acc_typ   = lsu_type_e'(rnd[1:0] % 3);
      acc_we    = rnd[16];
      acc_sext  = rnd[17];
      req_valid_i    <= 1'b1;
      req_we_i       <= acc_we;
      req_type_i     <= acc_typ;
      req_sign_ext_i <= acc_sext;
      req_addr_i     <= {24'h0, acc_addr};
      req_wdata_i    <= acc_wdata;
      waited   = 0;
      accepted = 1'b0;
      while (!accepted) begin
        @(posedge clk_i);
        accepted = req_ready_o;
        waited++;
        if (!accepted && waited > Timeout) abort_run("an access was not accepted in time");
      end
      expv = ref_access(acc_addr, acc_typ, acc_sext);
      exp_err.push_back(expv[32]);
      exp_rdata.push_back(expv[31:0]);
      exp_load.push_back(!acc_we);
      exp_addr.push_back({24'h0, acc_addr[7:2], 2'b00});
      exp_split.push_back(((acc_typ == LSU_WORD) && (acc_addr[1:0] != 2'b00)) ||
                          ((acc_typ == LSU_HALF) && (acc_addr[1:0] == 2'b11)));
      if (acc_we) store_shadow(acc_addr, acc_typ, acc_wdata);
      // occasional idle cycle between accesses
      if (rnd[31:29] == 3'b000) begin
        req_valid_i <= 1'b0;
        @(posedge clk_i);
      end
    end
    req_valid_i <= 1'b0;
    waited = 0;
    while (resp_count < NumAccess) begin
      @(posedge clk_i);
      waited++;
      if (waited > Timeout) abort_run("responses still missing after the last access");
    end
    if (resp_count == NumAccess && exp_err.size() == 0 && gnt_addr_q.size() == 0) begin
      $display("Test passed");
      $finish;
    end else begin
      abort_run("bus requests or responses left over at the end");
    end
  end

endmodule

//--- filelist.f
source/lsu_pkg.sv
source/lsu_ctrl_fsm.sv
source/lsu_wdata_align.sv
source/lsu_rdata_align.sv
source/lsu_top.sv
tb/lsu_sva.sv
tb/lsu_tb.sv

//--- run_sim.sh
#!/bin/sh
# compile and run the load/store unit testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
  --top-module lsu_tb -f filelist.f -o lsu_sim > build.log 2>&1 \
  || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/lsu_sim > sim.log 2>&1
cat sim.log
grep -q "Test failed" sim.log && exit 1
grep -q "Test passed" sim.log || exit 1
exit 0
